/* dv/axi_mem_props.sv */
`timescale 1ns/1ps

module axi_mem_props (
  input logic               clk,
  input logic               arst_n,
  input axi_pkg::axi_len_t  awlen,
  input logic               awvalid,
  input logic               awready,
  input logic               wvalid,
  input logic               wready,
  input axi_pkg::axi_id_t   bid,
  input logic               bvalid,
  input logic               bready,
  input axi_pkg::axi_data_t rdata,
  input logic               rlast,
  input logic               rvalid,
  input logic               rready
);
  import axi_pkg::*;

  int unsigned    fail_cnt = 0;  // Read by the testbench at the end.
  logic           wr_open;       // From AW transfer to B transfer.
  axi_len_t       len_q;
  logic [LEN_W:0] beat_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_open  <= 1'b0;
      len_q    <= '0;
      beat_cnt <= '0;
    end else if (awvalid && awready) begin
      wr_open  <= 1'b1;
      len_q    <= awlen;
      beat_cnt <= '0;
    end else begin
      if (wvalid && wready) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      if (bvalid && bready) begin
        wr_open <= 1'b0;
      end
    end
  end

  b_stable: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bid))
    else begin
      fail_cnt++;
      $error("bvalid or bid changed while bready was low");
    end

  r_stable: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
    else begin
      fail_cnt++;
      $error("rvalid, rdata or rlast changed while rready was low");
    end

  aw_blocked: assert property (@(posedge clk) disable iff (!arst_n)
    wr_open |-> !awready)
    else begin
      fail_cnt++;
      $error("awready was high while a write burst was open");
    end

  // Stands in for wlast, all awlen+1 beats are in before the response.
  w_beats: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(bvalid) |-> beat_cnt == {1'b0, len_q} + 1'b1)
    else begin
      fail_cnt++;
      $error("write beat count does not match the accepted awlen");
    end

endmodule

/* dv/axi_mem_tb.sv */
`timescale 1ns/1ps

module axi_mem_tb;
  import axi_pkg::*;
  import mem_pkg::*;

  localparam int unsigned NUM_TXN    = 60;
  localparam int unsigned MAX_BEATS  = 8;
  localparam int unsigned CLK_NS     = 100;
  localparam int unsigned TIMEOUT_NS = NUM_TXN * MAX_BEATS * 12 * CLK_NS;  // 12 cycles a beat.

  logic      clk;
  logic      arst_n;
  axi_id_t   awid, bid, arid, rid;
  axi_addr_t awaddr, araddr;
  axi_len_t  awlen, arlen;
  axi_data_t wdata, rdata;
  axi_strb_t wstrb;
  axi_resp_t bresp, rresp;
  logic      awvalid, awready, wvalid, wready, bvalid, bready;
  logic      arvalid, arready, rvalid, rready, rlast;
  csr_t      csr_o;

  // Reference model and a mask of the byte lanes written so far.
  axi_data_t   model_mem [MEM_WORDS];
  axi_strb_t   model_known [MEM_WORDS];
  csr_t        model_csr;
  int unsigned err_cnt;

  clk_gen clk_gen_i (.clk(clk));

  axi_mem_wrapper axi_mem_wrapper_i (.*);

  bind axi_mem_wrapper axi_mem_props props_i (.*);

  task automatic compare(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  function automatic axi_data_t lane_mask(input axi_strb_t strb);
    axi_data_t mask;
    for (int i = 0; i < STRB_W; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  // Low words or the top of the window so bursts overlap and wrap.
  function automatic axi_addr_t pick_addr();
    axi_addr_t addr;
    addr = $urandom;
    if ($urandom % 2 == 0) begin
      addr[BYTE_OFFS +: MEM_AW] = mem_addr_t'($urandom % 16);
    end else begin
      addr[BYTE_OFFS +: MEM_AW] = mem_addr_t'(MEM_WORDS - 8 + $urandom % 8);
    end
    addr[CSR_SEL_BIT]   = ($urandom % 4 == 0);
    addr[BYTE_OFFS-1:0] = '0;
    return addr;
  endfunction

  task automatic idle_cycles();
    repeat ($urandom % 4) @(negedge clk);
  endtask

  task automatic write_burst(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
    mem_addr_t word;
    axi_strb_t strb;
    word = addr[BYTE_OFFS +: MEM_AW];
    idle_cycles();
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awvalid = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      idle_cycles();
      strb   = axi_strb_t'($urandom % 16);
      wdata  = $urandom;
      wstrb  = strb;
      wvalid = 1'b1;
      while (!wready) @(negedge clk);
      @(negedge clk);
      wvalid = 1'b0;
      if (addr[CSR_SEL_BIT]) begin
        if (strb[0]) begin
          model_csr = wdata[CSR_W-1:0];
        end
      end else begin
        model_mem[word]   = (model_mem[word] & ~lane_mask(strb)) | (wdata & lane_mask(strb));
        model_known[word] = model_known[word] | strb;
      end
      word = word + 1'b1;
    end
    while (!bvalid) @(negedge clk);
    idle_cycles();
    compare("bid", axi_data_t'(id), axi_data_t'(bid));
    compare("bresp", axi_data_t'(RESP_OKAY), axi_data_t'(bresp));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    compare("bvalid", '0, axi_data_t'(bvalid));  // Exactly one response.
    compare("csr_o", axi_data_t'(model_csr), axi_data_t'(csr_o));
  endtask

  task automatic read_burst(input axi_addr_t addr, input axi_len_t len, input axi_id_t id);
    mem_addr_t word;
    axi_data_t exp;
    axi_data_t mask;
    word = addr[BYTE_OFFS +: MEM_AW];
    idle_cycles();
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      while (!rvalid) @(negedge clk);
      idle_cycles();
      if (addr[CSR_SEL_BIT]) begin
        exp  = axi_data_t'(model_csr);
        mask = '1;
      end else begin
        exp  = model_mem[word];
        mask = lane_mask(model_known[word]);
      end
      compare("rdata", exp & mask, rdata & mask);
      compare("rlast", axi_data_t'(beat == int'(len)), axi_data_t'(rlast));
      compare("rid", axi_data_t'(id), axi_data_t'(rid));
      compare("rresp", axi_data_t'(RESP_OKAY), axi_data_t'(rresp));
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      word   = word + 1'b1;
    end
    compare("rvalid", '0, axi_data_t'(rvalid));  // No beat past rlast.
  endtask

  initial begin
    axi_addr_t addr;
    axi_len_t  len;
    axi_id_t   id;
    void'($urandom(32'hde4e_8978));
    err_cnt   = 0;
    model_csr = '0;
    arst_n    = 1'b0;
    awid      = '0;
    awaddr    = '0;
    awlen     = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    arid      = '0;
    araddr    = '0;
    arlen     = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    foreach (model_known[i]) begin
      model_known[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    compare("bvalid", '0, axi_data_t'(bvalid));
    compare("rvalid", '0, axi_data_t'(rvalid));
    compare("awready", 32'd1, axi_data_t'(awready));
    compare("wready", '0, axi_data_t'(wready));
    compare("arready", 32'd1, axi_data_t'(arready));
    compare("csr_o", '0, axi_data_t'(csr_o));
    repeat (NUM_TXN) begin
      addr = pick_addr();
      len  = axi_len_t'($urandom % MAX_BEATS);
      id   = axi_id_t'($urandom % 2);
      if ($urandom % 2 == 0) begin
        write_burst(addr, len, id);
      end else begin
        read_burst(addr, len, id);
      end
    end
    compare("assertion failures", '0, axi_data_t'(axi_mem_wrapper_i.props_i.fail_cnt));
    $display("Finished %0d transactions with %0d errors", NUM_TXN, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, a handshake never completed", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;  // Half of the 100 ns period.
    end
  end

endmodule

/* filelist.f */
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/mem_port_if.sv
logic/mem_array.sv
logic/axi_wr_channel.sv
logic/axi_rd_channel.sv
logic/axi_mem_wrapper.sv
dv/clk_gen.sv
dv/axi_mem_props.sv
dv/axi_mem_tb.sv

/* logic/axi_mem_wrapper.sv */
`timescale 1ns/1ps

module axi_mem_wrapper (
  input  logic              clk,
  input  logic              arst_n,
  // Write address.
  input  axi_pkg::axi_id_t   awid,
  input  axi_pkg::axi_addr_t awaddr,
  input  axi_pkg::axi_len_t  awlen,
  input  logic              awvalid,
  output logic              awready,
  // Write data.
  input  axi_pkg::axi_data_t wdata,
  input  axi_pkg::axi_strb_t wstrb,
  input  logic              wvalid,
  output logic              wready,
  // Write response.
  output axi_pkg::axi_id_t   bid,
  output axi_pkg::axi_resp_t bresp,
  output logic              bvalid,
  input  logic              bready,
  // Read address.
  input  axi_pkg::axi_id_t   arid,
  input  axi_pkg::axi_addr_t araddr,
  input  axi_pkg::axi_len_t  arlen,
  input  logic              arvalid,
  output logic              arready,
  // Read data.
  output axi_pkg::axi_id_t   rid,
  output axi_pkg::axi_data_t rdata,
  output axi_pkg::axi_resp_t rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  output mem_pkg::csr_t      csr_o
);

  mem_port_if mem_if ();

  axi_wr_channel u_wr (
    .clk     (clk),
    .arst_n  (arst_n),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .csr     (csr_o),
    .mem     (mem_if.wr)
  );

  axi_rd_channel u_rd (
    .clk     (clk),
    .arst_n  (arst_n),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready),
    .csr     (csr_o),   // Read back of the control register.
    .mem     (mem_if.rd)
  );

  mem_array u_array (
    .clk (clk),
    .mem (mem_if.array)
  );

endmodule

/* logic/axi_pkg.sv */
package axi_pkg;

  // Bus geometry.
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned ID_W   = 1;
  localparam int unsigned RESP_W = 2;

  // Byte offset bits within one beat.
  localparam int unsigned BYTE_OFFS = $clog2(STRB_W);

  // Byte address.
  typedef logic [ADDR_W-1:0] axi_addr_t;

  // One data beat.
  typedef logic [DATA_W-1:0] axi_data_t;

  // One strobe bit per byte lane.
  typedef logic [STRB_W-1:0] axi_strb_t;

  // Burst length minus one.
  typedef logic [LEN_W-1:0] axi_len_t;

  // Transaction ID.
  typedef logic [ID_W-1:0] axi_id_t;

  // Response code.
  typedef logic [RESP_W-1:0] axi_resp_t;

  // Every response is OKAY.
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* logic/axi_rd_channel.sv */
`timescale 1ns/1ps

module axi_rd_channel (
  input  logic              clk,
  input  logic              arst_n,
  input  axi_pkg::axi_id_t   arid,
  input  axi_pkg::axi_addr_t araddr,
  input  axi_pkg::axi_len_t  arlen,
  input  logic              arvalid,
  output logic              arready,
  output axi_pkg::axi_id_t   rid,
  output axi_pkg::axi_data_t rdata,
  output axi_pkg::axi_resp_t rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  input  mem_pkg::csr_t      csr,
  mem_port_if.rd            mem
);
  import axi_pkg::*;
  import mem_pkg::*;

  rd_state_t state_q;
  rd_state_t state_d;
  axi_len_t  beats_q;   // Beats left after the current one.
  axi_id_t   id_q;
  mem_addr_t raddr_q;
  logic      csr_sel_q;
  csr_t      csr_snap_q;

  logic ar_fire;
  logic r_fire;

  assign arready = (state_q == RD_IDLE);
  assign rvalid  = (state_q == RD_DATA);
  assign rlast   = rvalid && (beats_q == '0);

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  assign rid   = id_q;
  assign rresp = RESP_OKAY;
  assign rdata = csr_sel_q ? {{(DATA_W-CSR_W){1'b0}}, csr_snap_q} : mem.rdata;

  // One array access per beat.
  assign mem.re    = (state_q == RD_FETCH);
  assign mem.raddr = raddr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE:  if (ar_fire) state_d = RD_FETCH;
      RD_FETCH: state_d = RD_DATA;
      RD_DATA:  if (r_fire) state_d = rlast ? RD_IDLE : RD_FETCH;
      default:  state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= RD_IDLE;
      beats_q <= '0;
    end else begin
      state_q <= state_d;
      if (ar_fire) begin
        beats_q <= arlen;
      end else if (r_fire && !rlast) begin
        beats_q <= beats_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q      <= arid;
      raddr_q   <= araddr[BYTE_OFFS +: MEM_AW];
      csr_sel_q <= araddr[CSR_SEL_BIT];
    end else if (r_fire) begin
      raddr_q <= raddr_q + 1'b1;
    end
    // Sampled with the array so rdata holds under back-pressure.
    if (mem.re) begin
      csr_snap_q <= csr;
    end
  end

endmodule

/* logic/axi_wr_channel.sv */
`timescale 1ns/1ps

module axi_wr_channel (
  input  logic              clk,
  input  logic              arst_n,
  input  axi_pkg::axi_id_t   awid,
  input  axi_pkg::axi_addr_t awaddr,
  input  axi_pkg::axi_len_t  awlen,
  input  logic              awvalid,
  output logic              awready,
  input  axi_pkg::axi_data_t wdata,
  input  axi_pkg::axi_strb_t wstrb,
  input  logic              wvalid,
  output logic              wready,
  output axi_pkg::axi_id_t   bid,
  output axi_pkg::axi_resp_t bresp,
  output logic              bvalid,
  input  logic              bready,
  output mem_pkg::csr_t      csr,
  mem_port_if.wr            mem
);
  import axi_pkg::*;
  import mem_pkg::*;

  wr_state_t state_q;
  wr_state_t state_d;
  axi_len_t  beats_q;   // Beats left after the current one.
  axi_id_t   id_q;
  mem_addr_t waddr_q;
  logic      csr_sel_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic last_beat;

  assign awready = (state_q == WR_IDLE);
  assign wready  = (state_q == WR_DATA);
  assign bvalid  = (state_q == WR_RESP);

  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign b_fire    = bvalid && bready;
  assign last_beat = (beats_q == '0);

  assign bid   = id_q;
  assign bresp = RESP_OKAY;

  // Beats of a CSR burst never reach the array.
  assign mem.we    = w_fire && !csr_sel_q;
  assign mem.waddr = waddr_q;
  assign mem.wdata = wdata;
  assign mem.wstrb = wstrb;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if (aw_fire) state_d = WR_DATA;
      WR_DATA: if (w_fire && last_beat) state_d = WR_RESP;
      WR_RESP: if (b_fire) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= WR_IDLE;
      beats_q <= '0;
      csr     <= '0;
    end else begin
      state_q <= state_d;
      if (aw_fire) begin
        beats_q <= awlen;
      end else if (w_fire && !last_beat) begin
        beats_q <= beats_q - 1'b1;
      end
      if (w_fire && csr_sel_q && wstrb[0]) begin
        csr <= wdata[CSR_W-1:0];  // Low byte lane only.
      end
    end
  end

  // Burst context, wraps within the 4 KB window.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q      <= awid;
      waddr_q   <= awaddr[BYTE_OFFS +: MEM_AW];
      csr_sel_q <= awaddr[CSR_SEL_BIT];
    end else if (w_fire) begin
      waddr_q <= waddr_q + 1'b1;
    end
  end

endmodule

/* logic/mem_array.sv */
`timescale 1ns/1ps

module mem_array (
  input logic       clk,
  mem_port_if.array mem
);
  import axi_pkg::*;
  import mem_pkg::*;

  axi_data_t ram [MEM_WORDS];

  // Per-lane write.
  always_ff @(posedge clk) begin
    if (mem.we) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (mem.wstrb[i]) begin
          ram[mem.waddr][8*i +: 8] <= mem.wdata[8*i +: 8];
        end
      end
    end
  end

  // Old data on a same-cycle read and write.
  always_ff @(posedge clk) begin
    if (mem.re) begin
      mem.rdata <= ram[mem.raddr];
    end
  end

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

  // Size of the on-chip RAM.
  localparam int unsigned MEM_KB = 4;

  // 4 bytes per word.
  localparam int unsigned MEM_WORDS = MEM_KB * 1024 / 4;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // Byte address bit 12 selects the control register region.
  localparam int unsigned CSR_SEL_BIT = 12;
  localparam int unsigned CSR_W       = 8;

  // Word address into the array.
  typedef logic [MEM_AW-1:0] mem_addr_t;

  // Control register.
  typedef logic [CSR_W-1:0] csr_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_DATA
  } rd_state_t;

endpackage

/* logic/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;
  import axi_pkg::*;
  import mem_pkg::*;

  // Write port.
  logic      we;
  mem_addr_t waddr;
  axi_data_t wdata;
  axi_strb_t wstrb;

  // Read port, data is registered in the array.
  logic      re;
  mem_addr_t raddr;
  axi_data_t rdata;

  modport wr (
    output we, waddr, wdata, wstrb
  );

  modport rd (
    output re, raddr,
    input  rdata
  );

  modport array (
    input  we, waddr, wdata, wstrb, re, raddr,
    output rdata
  );

endinterface

/* run.sh */
#!/bin/sh
# Build and run the AXI memory testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module axi_mem_tb -o axi_mem_sim &&
  ./obj_dir/axi_mem_sim +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "^TEST RESULT: PASS$" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
